//--- hdl/audio_pkg.sv
package audio_pkg;

    // ==================================================
    // audio data path
    // ==================================================

    // bits per codec sample, left channel only
    localparam int SAMPLE_W  = 16;

    // external SRAM word address
    localparam int ADDR_W    = 20;

    // recording stops by itself once this many words are stored
    localparam int MAX_WORDS = 1024000;

    // bit counter runs 0 to SAMPLE_W
    localparam int BIT_CNT_W = 5;

endpackage

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    // width of every state and mode register
    localparam int STATE_W = 3;

    // ==================================================
    // recorder FSM
    // ==================================================
    localparam logic [STATE_W-1:0] S_REC_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] S_REC_WAIT    = 3'd1;
    localparam logic [STATE_W-1:0] S_REC_CAPTURE = 3'd2;
    localparam logic [STATE_W-1:0] S_REC_PAUSE   = 3'd3;

    // ==================================================
    // player FSM
    // ==================================================
    localparam logic [STATE_W-1:0] S_PLAY_IDLE   = 3'd0;
    localparam logic [STATE_W-1:0] S_PLAY_WAIT   = 3'd1;
    localparam logic [STATE_W-1:0] S_PLAY_SHIFT  = 3'd2;
    localparam logic [STATE_W-1:0] S_PLAY_PAUSE  = 3'd3;

    // control modes
    localparam logic [STATE_W-1:0] MODE_IDLE     = 3'd0;
    localparam logic [STATE_W-1:0] MODE_REC      = 3'd1;
    localparam logic [STATE_W-1:0] MODE_PLAY     = 3'd2;

endpackage

//--- hdl/aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder
    import audio_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_rec_start,
    input  logic                i_pause_toggle,
    input  logic                i_stop,
    input  logic                i_adclrck,
    input  logic                i_adcdat,
    output logic                o_wr_en,
    output logic [ADDR_W-1:0]   o_wr_addr,
    output logic [SAMPLE_W-1:0] o_wr_data,
    output logic                o_rec_done,
    output logic [ADDR_W:0]     o_rec_words,
    output logic                o_paused
);

logic [STATE_W-1:0]   state_r, state_w;
logic [ADDR_W-1:0]    addr_r, addr_w;
logic [SAMPLE_W-1:0]  data_r, data_w;
logic [BIT_CNT_W-1:0] cnt_r, cnt_w;
logic                 wr_en_r, wr_en_w;
logic                 done_r, done_w;
logic                 pend_r, pend_w;
logic                 lrc_r;
logic                 lrc_fall;
logic                 full;

// left channel starts when the LR clock drops
assign lrc_fall = lrc_r && !i_adclrck;

// last free word is being written right now
assign full = wr_en_r && (addr_r == ADDR_W'(MAX_WORDS - 1));

assign o_wr_en     = wr_en_r;
assign o_wr_addr   = addr_r;
assign o_wr_data   = data_r;
assign o_rec_done  = done_r;
assign o_rec_words = {1'b0, addr_r};
assign o_paused    = (state_r == S_REC_PAUSE);

always_comb begin
    state_w = state_r;
    addr_w  = addr_r;
    data_w  = data_r;
    cnt_w   = cnt_r;
    pend_w  = pend_r;
    wr_en_w = 1'b0;
    done_w  = 1'b0;
    // address moves on at the end of the write cycle
    if (wr_en_r) begin
        addr_w = addr_r + 1'b1;
    end
    case (state_r)
        S_REC_IDLE: begin
            if (i_rec_start) begin
                addr_w  = '0;
                pend_w  = 1'b0;
                state_w = S_REC_WAIT;
            end
        end
        S_REC_WAIT: begin
            if (i_stop || full) begin
                done_w  = 1'b1;
                pend_w  = 1'b0;
                state_w = S_REC_IDLE;
            end
            else if (pend_r || i_pause_toggle) begin
                pend_w  = 1'b0;
                state_w = S_REC_PAUSE;
            end
            else if (lrc_fall) begin
                // MSB is already on the line at the fall
                data_w  = {data_r[SAMPLE_W-2:0], i_adcdat};
                cnt_w   = BIT_CNT_W'(1);
                state_w = S_REC_CAPTURE;
            end
        end
        S_REC_CAPTURE: begin
            data_w = {data_r[SAMPLE_W-2:0], i_adcdat};
            cnt_w  = cnt_r + 1'b1;
            if (i_pause_toggle) begin
                pend_w = 1'b1;
            end
            if (i_stop) begin
                // partial word is dropped
                pend_w  = 1'b0;
                done_w  = 1'b1;
                state_w = S_REC_IDLE;
            end
            else if (cnt_r == BIT_CNT_W'(SAMPLE_W - 1)) begin
                wr_en_w = 1'b1;
                state_w = S_REC_WAIT;
            end
        end
        S_REC_PAUSE: begin
            if (i_stop) begin
                done_w  = 1'b1;
                state_w = S_REC_IDLE;
            end
            else if (i_pause_toggle) begin
                state_w = S_REC_WAIT;
            end
        end
        default: begin
            state_w = S_REC_IDLE;
        end
    endcase
end

always_ff @(negedge i_clk) begin
    if (i_rst_n) begin
        state_r <= S_REC_IDLE;
        addr_r  <= '0;
        cnt_r   <= '0;
        wr_en_r <= 1'b0;
        done_r  <= 1'b0;
        pend_r  <= 1'b0;
        lrc_r   <= 1'b0;
    end
    else begin
        state_r <= state_w;
        addr_r  <= addr_w;
        cnt_r   <= cnt_w;
        wr_en_r <= wr_en_w;
        done_r  <= done_w;
        pend_r  <= pend_w;
        lrc_r   <= i_adclrck;
    end
end

// sample shift register
always_ff @(negedge i_clk) begin
    data_r <= data_w;
end

// ==================================================
// checks
// ==================================================
a_no_write_in_pause: assert property (@(negedge i_clk) disable iff (i_rst_n)
    (state_r == S_REC_PAUSE) |-> !o_wr_en)
    else $error("aud_recorder: write strobe while paused");

a_write_in_range: assert property (@(negedge i_clk) disable iff (i_rst_n)
    o_wr_en |-> (o_wr_addr < MAX_WORDS))
    else $error("aud_recorder: write address beyond capacity");

endmodule

//--- hdl/aud_player.sv
`timescale 1ns/1ps

module aud_player
    import audio_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_play_start,
    input  logic                i_pause_toggle,
    input  logic                i_stop,
    input  logic                i_daclrck,
    input  logic [SAMPLE_W-1:0] i_rd_data,
    input  logic [ADDR_W:0]     i_play_words,
    output logic [ADDR_W-1:0]   o_rd_addr,
    output logic                o_dacdat,
    output logic                o_play_done,
    output logic                o_paused
);

logic [STATE_W-1:0]   state_r, state_w;
logic [ADDR_W-1:0]    addr_r, addr_w;
logic [SAMPLE_W-1:0]  shift_r, shift_w;
logic [BIT_CNT_W-1:0] cnt_r, cnt_w;
logic                 done_r, done_w;
logic                 lrc_r;
logic                 lrc_fall;
logic [ADDR_W:0]      words_next;

assign lrc_fall   = lrc_r && !i_daclrck;
assign words_next = {1'b0, addr_r} + 1'b1;

// zeros fill in behind the word, so the line idles low
assign o_dacdat    = shift_r[SAMPLE_W-1];
assign o_rd_addr   = addr_r;
assign o_play_done = done_r;
assign o_paused    = (state_r == S_PLAY_PAUSE);

always_comb begin
    state_w = state_r;
    addr_w  = addr_r;
    shift_w = shift_r;
    cnt_w   = cnt_r;
    done_w  = 1'b0;
    case (state_r)
        S_PLAY_IDLE: begin
            if (i_play_start) begin
                addr_w = '0;
                if (i_play_words == '0) begin
                    done_w = 1'b1;
                end
                else begin
                    state_w = S_PLAY_WAIT;
                end
            end
        end
        S_PLAY_WAIT: begin
            if (i_stop) begin
                done_w  = 1'b1;
                state_w = S_PLAY_IDLE;
            end
            else if (i_pause_toggle) begin
                state_w = S_PLAY_PAUSE;
            end
            else if (lrc_fall) begin
                shift_w = i_rd_data;
                cnt_w   = '0;
                state_w = S_PLAY_SHIFT;
            end
        end
        S_PLAY_SHIFT: begin
            shift_w = {shift_r[SAMPLE_W-2:0], 1'b0};
            cnt_w   = cnt_r + 1'b1;
            if (i_stop) begin
                shift_w = '0;
                done_w  = 1'b1;
                state_w = S_PLAY_IDLE;
            end
            else if (i_pause_toggle) begin
                // address held, word is replayed on resume
                shift_w = '0;
                state_w = S_PLAY_PAUSE;
            end
            else if (cnt_r == BIT_CNT_W'(SAMPLE_W - 1)) begin
                addr_w = addr_r + 1'b1;
                if (words_next == i_play_words) begin
                    done_w  = 1'b1;
                    state_w = S_PLAY_IDLE;
                end
                else begin
                    state_w = S_PLAY_WAIT;
                end
            end
        end
        S_PLAY_PAUSE: begin
            if (i_stop) begin
                done_w  = 1'b1;
                state_w = S_PLAY_IDLE;
            end
            else if (i_pause_toggle) begin
                state_w = S_PLAY_WAIT;
            end
        end
        default: begin
            state_w = S_PLAY_IDLE;
        end
    endcase
end

always_ff @(negedge i_clk) begin
    if (i_rst_n) begin
        state_r <= S_PLAY_IDLE;
        addr_r  <= '0;
        shift_r <= '0;
        cnt_r   <= '0;
        done_r  <= 1'b0;
        lrc_r   <= 1'b0;
    end
    else begin
        state_r <= state_w;
        addr_r  <= addr_w;
        shift_r <= shift_w;
        cnt_r   <= cnt_w;
        done_r  <= done_w;
        lrc_r   <= i_daclrck;
    end
end

// right channel is always sent as silence
a_right_silent: assert property (@(negedge i_clk) disable iff (i_rst_n)
    i_daclrck |-> !o_dacdat)
    else $error("aud_player: data on the right channel");

endmodule

//--- hdl/aud_ctrl.sv
`timescale 1ns/1ps

module aud_ctrl
    import audio_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_key_rec,
    input  logic                i_key_play,
    input  logic                i_key_pause,
    input  logic                i_key_stop,
    input  logic                i_wr_en,
    input  logic [ADDR_W-1:0]   i_wr_addr,
    input  logic [SAMPLE_W-1:0] i_wr_data,
    input  logic                i_rec_done,
    input  logic [ADDR_W:0]     i_rec_words,
    input  logic [ADDR_W-1:0]   i_rd_addr,
    input  logic                i_play_done,
    output logic                o_rec_start,
    output logic                o_play_start,
    output logic                o_pause_toggle,
    output logic                o_stop,
    output logic [ADDR_W:0]     o_play_words,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    output logic                o_sram_we_n,
    output logic                o_recording,
    output logic                o_playing
);

logic                 key_rec_r, key_play_r, key_pause_r, key_stop_r;
logic                 rel_rec, rel_play, rel_pause, rel_stop;
logic [STATE_W-1:0]   mode_r, mode_w;
logic [ADDR_W:0]      words_r, words_w;
logic                 rec_start_r, rec_start_w;
logic                 play_start_r, play_start_w;
logic                 pause_r, pause_w;
logic                 stop_r, stop_w;

// ==================================================
// key release detect
// ==================================================
assign rel_rec   = key_rec_r   && !i_key_rec;
assign rel_play  = key_play_r  && !i_key_play;
assign rel_pause = key_pause_r && !i_key_pause;
assign rel_stop  = key_stop_r  && !i_key_stop;

assign o_rec_start    = rec_start_r;
assign o_play_start   = play_start_r;
assign o_pause_toggle = pause_r;
assign o_stop         = stop_r;
assign o_play_words   = words_r;
assign o_recording    = (mode_r == MODE_REC);
assign o_playing      = (mode_r == MODE_PLAY);

// SRAM port, recorder owns the address only while recording
assign o_sram_addr  = (mode_r == MODE_REC) ? i_wr_addr : i_rd_addr;
assign o_sram_wdata = i_wr_data;
assign o_sram_we_n  = !i_wr_en;

always_comb begin
    mode_w       = mode_r;
    words_w      = words_r;
    rec_start_w  = 1'b0;
    play_start_w = 1'b0;
    pause_w      = 1'b0;
    stop_w       = 1'b0;
    case (mode_r)
        MODE_IDLE: begin
            if (rel_rec) begin
                rec_start_w = 1'b1;
                mode_w      = MODE_REC;
            end
            else if (rel_play) begin
                play_start_w = 1'b1;
                mode_w       = MODE_PLAY;
            end
        end
        MODE_REC: begin
            if (i_rec_done) begin
                words_w = i_rec_words;
                mode_w  = MODE_IDLE;
            end
            else if (rel_stop) begin
                stop_w = 1'b1;
            end
            else if (rel_pause) begin
                pause_w = 1'b1;
            end
        end
        MODE_PLAY: begin
            if (i_play_done) begin
                mode_w = MODE_IDLE;
            end
            else if (rel_stop) begin
                stop_w = 1'b1;
            end
            else if (rel_pause) begin
                pause_w = 1'b1;
            end
        end
        default: begin
            mode_w = MODE_IDLE;
        end
    endcase
end

always_ff @(negedge i_clk) begin
    if (i_rst_n) begin
        key_rec_r    <= 1'b0;
        key_play_r   <= 1'b0;
        key_pause_r  <= 1'b0;
        key_stop_r   <= 1'b0;
        mode_r       <= MODE_IDLE;
        words_r      <= '0;
        rec_start_r  <= 1'b0;
        play_start_r <= 1'b0;
        pause_r      <= 1'b0;
        stop_r       <= 1'b0;
    end
    else begin
        key_rec_r    <= i_key_rec;
        key_play_r   <= i_key_play;
        key_pause_r  <= i_key_pause;
        key_stop_r   <= i_key_stop;
        mode_r       <= mode_w;
        words_r      <= words_w;
        rec_start_r  <= rec_start_w;
        play_start_r <= play_start_w;
        pause_r      <= pause_w;
        stop_r       <= stop_w;
    end
end

// recorder writes must never leak into playback
a_write_only_recording: assert property (@(negedge i_clk) disable iff (i_rst_n)
    !o_sram_we_n |-> (mode_r == MODE_REC))
    else $error("aud_ctrl: SRAM write outside record mode");

endmodule

//--- hdl/aud_core.sv
`timescale 1ns/1ps

module aud_core
    import audio_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_key_rec,
    input  logic                i_key_play,
    input  logic                i_key_pause,
    input  logic                i_key_stop,
    input  logic                i_adclrck,
    input  logic                i_adcdat,
    input  logic                i_daclrck,
    input  logic [SAMPLE_W-1:0] i_sram_rdata,
    output logic                o_dacdat,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    output logic                o_sram_we_n,
    output logic                o_recording,
    output logic                o_playing,
    output logic                o_paused,
    output logic                o_rec_done,
    output logic                o_play_done
);

logic                rec_start, play_start, pause_toggle, stop;
logic                wr_en;
logic [ADDR_W-1:0]   wr_addr;
logic [SAMPLE_W-1:0] wr_data;
logic                rec_done, play_done;
logic [ADDR_W:0]     rec_words, play_words;
logic [ADDR_W-1:0]   rd_addr;
logic                rec_paused, play_paused;

assign o_paused    = rec_paused || play_paused;
assign o_rec_done  = rec_done;
assign o_play_done = play_done;

// ==================================================
// keys, mode and SRAM port
// ==================================================
aud_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_key_rec      (i_key_rec),
    .i_key_play     (i_key_play),
    .i_key_pause    (i_key_pause),
    .i_key_stop     (i_key_stop),
    .i_wr_en        (wr_en),
    .i_wr_addr      (wr_addr),
    .i_wr_data      (wr_data),
    .i_rec_done     (rec_done),
    .i_rec_words    (rec_words),
    .i_rd_addr      (rd_addr),
    .i_play_done    (play_done),
    .o_rec_start    (rec_start),
    .o_play_start   (play_start),
    .o_pause_toggle (pause_toggle),
    .o_stop         (stop),
    .o_play_words   (play_words),
    .o_sram_addr    (o_sram_addr),
    .o_sram_wdata   (o_sram_wdata),
    .o_sram_we_n    (o_sram_we_n),
    .o_recording    (o_recording),
    .o_playing      (o_playing)
);

// ADC side
aud_recorder u_recorder (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_rec_start    (rec_start),
    .i_pause_toggle (pause_toggle && o_recording),
    .i_stop         (stop && o_recording),
    .i_adclrck      (i_adclrck),
    .i_adcdat       (i_adcdat),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_rec_done     (rec_done),
    .o_rec_words    (rec_words),
    .o_paused       (rec_paused)
);

// DAC side
aud_player u_player (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_play_start   (play_start),
    .i_pause_toggle (pause_toggle && o_playing),
    .i_stop         (stop && o_playing),
    .i_daclrck      (i_daclrck),
    .i_rd_data      (i_sram_rdata),
    .i_play_words   (play_words),
    .o_rd_addr      (rd_addr),
    .o_dacdat       (o_dacdat),
    .o_play_done    (play_done),
    .o_paused       (play_paused)
);

endmodule

//--- tests/sram_model.sv
`timescale 1ns/1ps

module sram_model
    import audio_pkg::*;
(
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [SAMPLE_W-1:0] i_wdata,
    input  logic                i_we_n,
    output logic [SAMPLE_W-1:0] o_rdata
);

// reachable from the testbench for preload and readback
logic [SAMPLE_W-1:0] mem [0:(1 << ADDR_W) - 1];

// asynchronous read
assign o_rdata = mem[i_addr];

initial begin
    int a;
    // fill word mixes the high and low address bits
    for (a = 0; a < (1 << ADDR_W); a++) begin
        mem[ADDR_W'(a)] = SAMPLE_W'(a >> 4) ^ SAMPLE_W'(a);
    end
    // write lands inside the strobe once address and data have settled
    forever begin
        @(negedge i_we_n);
        #1;
        if (!i_we_n) begin
            mem[i_addr] = i_wdata;
        end
    end
end

endmodule

//--- tests/tb_aud_core.sv
`timescale 1ns/1ps

module tb_aud_core
    import audio_pkg::*;
();

logic                clk = 1'b0;
logic                rst_n;
logic                key_rec, key_play, key_pause, key_stop;
logic                adclrck, adcdat, daclrck;
logic [SAMPLE_W-1:0] sram_rdata;
logic                dacdat;
logic [ADDR_W-1:0]   sram_addr;
logic [SAMPLE_W-1:0] sram_wdata;
logic                sram_we_n;
logic                recording, playing, paused, rec_done, play_done;

logic                codec_on;
int                  frame_no;
int                  frame_pos;
logic [15:0]         sent_q[$];
logic [15:0]         force_q[$];
logic [15:0]         exp_q[$];
int                  errors = 0;
int                  tests = 0;
int                  fails = 0;

aud_core UUT (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_key_rec    (key_rec),
    .i_key_play   (key_play),
    .i_key_pause  (key_pause),
    .i_key_stop   (key_stop),
    .i_adclrck    (adclrck),
    .i_adcdat     (adcdat),
    .i_daclrck    (daclrck),
    .i_sram_rdata (sram_rdata),
    .o_dacdat     (dacdat),
    .o_sram_addr  (sram_addr),
    .o_sram_wdata (sram_wdata),
    .o_sram_we_n  (sram_we_n),
    .o_recording  (recording),
    .o_playing    (playing),
    .o_paused     (paused),
    .o_rec_done   (rec_done),
    .o_play_done  (play_done)
);

sram_model u_sram (
    .i_addr  (sram_addr),
    .i_wdata (sram_wdata),
    .i_we_n  (sram_we_n),
    .o_rdata (sram_rdata)
);

always #2 clk = ~clk;

// ==================================================
// codec frames, 20 clocks left then 20 right
// ==================================================
task automatic drive_frame();
    logic [SAMPLE_W-1:0] s;
    int k;
    if (force_q.size() > 0) begin
        s = force_q.pop_front();
    end
    else begin
        s = SAMPLE_W'($urandom);
    end
    sent_q.push_back(s);
    for (k = 0; k < 40; k++) begin
        @(posedge clk);
        frame_no  <= sent_q.size() - 1;
        frame_pos <= k;
        adclrck   <= (k >= 20);
        daclrck   <= (k >= 20);
        if (k < SAMPLE_W) begin
            adcdat <= s[SAMPLE_W-1-k];
        end
        else if (k < 20) begin
            adcdat <= 1'b0;
        end
        else begin
            // right channel noise
            adcdat <= 1'($urandom);
        end
    end
endtask

always begin
    if (codec_on) begin
        drive_frame();
    end
    else begin
        @(posedge clk);
    end
end

task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        errors++;
    end
endtask

// 0 rec, 1 play, 2 pause, 3 stop
task automatic set_key(input int id, input logic v);
    case (id)
        0: key_rec <= v;
        1: key_play <= v;
        2: key_pause <= v;
        default: key_stop <= v;
    endcase
endtask

// command fires on release
task automatic press_key(input int id);
    @(posedge clk);
    set_key(id, 1'b1);
    repeat (2) @(posedge clk);
    set_key(id, 1'b0);
endtask

// frame counters are stable at the falling edge
task automatic wait_pos(input int f, input int p);
    int n;
    logic hit;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        hit = (f < 0 || frame_no == f) && frame_pos == p;
    end while (!hit && n < 8000);
    if (!hit) begin
        $display("timeout at %0t ns: frame %0d position %0d never reached", $time, f, p);
        errors++;
    end
endtask

task automatic wait_done(input int sel, input string what);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < 400) begin
        @(posedge clk);
        seen = (sel == 0) ? rec_done : play_done;
        n++;
    end
    if (!seen) begin
        $display("timeout at %0t ns: no %s pulse seen", $time, what);
        errors++;
    end
endtask

// recording starts in a right phase, so the next frame is the first captured
task automatic start_rec(output int f0);
    wait_pos(-1, 22);
    f0 = frame_no + 1;
    press_key(0);
endtask

task automatic capture_frame(input int f, output logic [15:0] w, output logic done_seen);
    int k;
    w = '0;
    done_seen = 1'b0;
    wait_pos(f, 0);
    for (k = 1; k < 40; k++) begin
        @(posedge clk);
        if (k <= SAMPLE_W) begin
            w = {w[14:0], dacdat};
        end
        else begin
            check_val(32'(dacdat), 32'd0, "o_dacdat outside the left sample");
        end
        if (play_done) begin
            done_seen = 1'b1;
        end
    end
endtask

task automatic play_and_check();
    int g, i;
    logic [15:0] w;
    logic done_seen;
    wait_pos(-1, 22);
    g = frame_no;
    press_key(1);
    for (i = 0; i < exp_q.size(); i++) begin
        capture_frame(g + 1 + i, w, done_seen);
        check_val(32'(w), 32'(exp_q[i]), $sformatf("played word %0d", i));
        check_val(32'(done_seen), 32'(i == exp_q.size() - 1), "o_play_done placement");
    end
    @(posedge clk);
    check_val(32'(playing), 32'd0, "o_playing after playback");
endtask

task automatic end_test(input string name, input int err0);
    tests++;
    if (errors != err0) begin
        fails++;
    end
    $display("%s: %0d mismatches", name, errors - err0);
endtask

// ==================================================
// directed tests
// ==================================================
task automatic test_record();
    int err0, f0, i;
    err0 = errors;
    @(posedge clk);
    check_val(32'(recording), 32'd0, "o_recording after reset");
    check_val(32'(playing), 32'd0, "o_playing after reset");
    check_val(32'(paused), 32'd0, "o_paused after reset");
    check_val(32'(dacdat), 32'd0, "o_dacdat after reset");
    check_val(32'(sram_we_n), 32'd1, "o_sram_we_n after reset");
    start_rec(f0);
    wait_pos(f0 + 7, 22);
    press_key(3);
    wait_done(0, "o_rec_done");
    for (i = 0; i < 8; i++) begin
        check_val(32'(u_sram.mem[ADDR_W'(i)]), 32'(sent_q[f0 + i]),
                  $sformatf("recorded word %0d", i));
    end
    end_test("record", err0);
endtask

task automatic test_pause();
    int err0, f0, i, idx;
    logic [15:0] old5;
    err0 = errors;
    old5 = u_sram.mem[ADDR_W'(5)];
    start_rec(f0);
    wait_pos(f0 + 2, 2);
    press_key(2);
    wait_pos(f0 + 3, 10);
    @(posedge clk);
    check_val(32'(paused), 32'd1, "o_paused while paused");
    wait_pos(f0 + 5, 22);
    press_key(2);
    wait_pos(f0 + 7, 22);
    @(posedge clk);
    check_val(32'(paused), 32'd0, "o_paused after resume");
    press_key(3);
    wait_done(0, "o_rec_done");
    // three frames skipped while paused
    for (i = 0; i < 5; i++) begin
        idx = (i < 3) ? f0 + i : f0 + i + 3;
        check_val(32'(u_sram.mem[ADDR_W'(i)]), 32'(sent_q[idx]),
                  $sformatf("word %0d around pause", i));
    end
    check_val(32'(u_sram.mem[ADDR_W'(5)]), 32'(old5), "word past the recording");
    end_test("pause", err0);
endtask

task automatic test_stop_mid_word();
    int err0, f0;
    logic [15:0] old2;
    err0 = errors;
    old2 = u_sram.mem[ADDR_W'(2)];
    start_rec(f0);
    wait_pos(f0 + 2, 2);
    press_key(3);
    wait_done(0, "o_rec_done");
    check_val(32'(u_sram.mem[ADDR_W'(0)]), 32'(sent_q[f0]), "word 0 before stop");
    check_val(32'(u_sram.mem[ADDR_W'(1)]), 32'(sent_q[f0 + 1]), "word 1 before stop");
    check_val(32'(u_sram.mem[ADDR_W'(2)]), 32'(old2), "partial word dropped");
    exp_q.delete();
    exp_q.push_back(sent_q[f0]);
    exp_q.push_back(sent_q[f0 + 1]);
    play_and_check();
    end_test("stop_mid_word", err0);
endtask

task automatic test_playback();
    int err0, f0, i;
    logic [15:0] w;
    err0 = errors;
    exp_q.delete();
    for (i = 0; i < 6; i++) begin
        w = 16'($urandom);
        u_sram.mem[ADDR_W'(i)] = w;
        exp_q.push_back(w);
    end
    // record the same words to set the length
    start_rec(f0);
    for (i = 0; i < 6; i++) begin
        force_q.push_back(exp_q[i]);
    end
    wait_pos(f0 + 5, 22);
    press_key(3);
    wait_done(0, "o_rec_done");
    for (i = 0; i < 6; i++) begin
        check_val(32'(u_sram.mem[ADDR_W'(i)]), 32'(exp_q[i]), $sformatf("stored word %0d", i));
    end
    play_and_check();
    end_test("playback", err0);
endtask

task automatic test_busy_keys();
    int err0, n;
    err0 = errors;
    wait_pos(-1, 22);
    press_key(1);
    wait_pos(-1, 5);
    press_key(0);
    for (n = 0; n < 60; n++) begin
        @(posedge clk);
        check_val(32'(recording), 32'd0, "o_recording during playback");
        check_val(32'(sram_we_n), 32'd1, "o_sram_we_n during playback");
        check_val(32'(playing), 32'd1, "o_playing during playback");
    end
    press_key(3);
    wait_done(1, "o_play_done");
    @(posedge clk);
    check_val(32'(playing), 32'd0, "o_playing after stop");
    end_test("busy_keys", err0);
endtask

initial begin
    void'($urandom(32'h128c_d9b0));
    rst_n     = 1'b1;
    key_rec   = 1'b0;
    key_play  = 1'b0;
    key_pause = 1'b0;
    key_stop  = 1'b0;
    adclrck   = 1'b1;
    daclrck   = 1'b1;
    adcdat    = 1'b0;
    codec_on  = 1'b0;
    frame_no  = -1;
    frame_pos = 0;
    repeat (8) @(posedge clk);
    rst_n    <= 1'b0;
    codec_on <= 1'b1;
    test_record();
    test_pause();
    test_stop_mid_word();
    test_playback();
    test_busy_keys();
    $display("%0d tests, %0d with mismatches, %0d mismatches in all", tests, fails, errors);
    if (errors == 0) begin
        $display("Test completed successfully");
    end
    else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

//--- aud_core.f
hdl/audio_pkg.sv
hdl/ctrl_pkg.sv
hdl/aud_recorder.sv
hdl/aud_player.sv
hdl/aud_ctrl.sv
hdl/aud_core.sv
tests/sram_model.sv
tests/tb_aud_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_aud_core -f aud_core.f

./obj_dir/Vtb_aud_core > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
else
    exit 1
fi
